// File: cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define DATA_W        8
`define INSTR_W       32
`define PC_W          32

// register file
`define REG_COUNT     8
`define REG_ADDR_W    3

// data cache geometry, 4-byte blocks
`define CACHE_LINES   8
`define BLOCK_W       32
`define TAG_W         3
`define BLOCK_ADDR_W  6

// opcodes, instruction bits 31..24
`define OP_LOADI      8'h00
`define OP_MOV        8'h01
`define OP_ADD        8'h02
`define OP_SUB        8'h03
`define OP_AND        8'h04
`define OP_OR         8'h05
`define OP_BEQ        8'h06
`define OP_J          8'h07
`define OP_LWD        8'h08
`define OP_LWI        8'h09
`define OP_SWD        8'h0a
`define OP_SWI        8'h0b

// alu selects
`define ALU_FWD       3'b000
`define ALU_ADD       3'b001
`define ALU_AND       3'b010
`define ALU_OR        3'b011
`define ALU_CMP       3'b100

`endif

// File: cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`DATA_W-1:0]       data_t;       // data byte or data address
    typedef logic [`INSTR_W-1:0]      instr_t;
    typedef logic [`PC_W-1:0]         pc_t;
    typedef logic [`REG_ADDR_W-1:0]   reg_addr_t;
    typedef logic [7:0]               opcode_t;
    typedef logic [2:0]               alu_sel_t;
    typedef logic [`BLOCK_W-1:0]      block_t;
    typedef logic [`BLOCK_ADDR_W-1:0] block_addr_t;

    // decoded control for one instruction
    typedef struct packed {
        alu_sel_t alu_sel;
        logic     use_reg_operand;  // src2 register instead of immediate
        logic     negate;           // two's complement of operand 2
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     wb_from_mem;      // load data back to dest
        logic     branch;
        logic     jump;
    } ctrl_t;

    // block request towards data memory
    typedef struct packed {
        logic        read;
        logic        write;
        block_addr_t block_addr;
        block_t      writedata;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        MEM_READ,
        UPDATE
    } cache_state_e;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instr_decoder (
    input  cpu_pkg::instr_t instruction,
    output cpu_pkg::ctrl_t  ctrl
);

    cpu_pkg::opcode_t opcode;

    assign opcode = instruction[31:24];

    always_comb begin
        ctrl = '0;  // unknown opcodes fall through as no-ops
        case (opcode)
            `OP_LOADI: begin
                ctrl.alu_sel   = `ALU_FWD;
                ctrl.reg_write = 1'b1;
            end
            `OP_MOV: begin
                ctrl.alu_sel         = `ALU_FWD;
                ctrl.use_reg_operand = 1'b1;
                ctrl.reg_write       = 1'b1;
            end
            `OP_ADD: begin
                ctrl.alu_sel         = `ALU_ADD;
                ctrl.use_reg_operand = 1'b1;
                ctrl.reg_write       = 1'b1;
            end
            `OP_SUB: begin
                ctrl.alu_sel         = `ALU_ADD;  // add of the negated operand
                ctrl.use_reg_operand = 1'b1;
                ctrl.negate          = 1'b1;
                ctrl.reg_write       = 1'b1;
            end
            `OP_AND: begin
                ctrl.alu_sel         = `ALU_AND;
                ctrl.use_reg_operand = 1'b1;
                ctrl.reg_write       = 1'b1;
            end
            `OP_OR: begin
                ctrl.alu_sel         = `ALU_OR;
                ctrl.use_reg_operand = 1'b1;
                ctrl.reg_write       = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.alu_sel         = `ALU_CMP;
                ctrl.use_reg_operand = 1'b1;
                ctrl.branch          = 1'b1;
            end
            `OP_J: begin
                ctrl.jump = 1'b1;
            end
            `OP_LWD: begin
                ctrl.use_reg_operand = 1'b1;  // address from src2
                ctrl.mem_read        = 1'b1;
                ctrl.reg_write       = 1'b1;
                ctrl.wb_from_mem     = 1'b1;
            end
            `OP_LWI: begin
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.wb_from_mem = 1'b1;
            end
            `OP_SWD: begin
                ctrl.use_reg_operand = 1'b1;
                ctrl.mem_write       = 1'b1;
            end
            `OP_SWI: begin
                ctrl.mem_write = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic               clock,
    input  logic               reset,
    input  cpu_pkg::ctrl_t     ctrl,
    input  logic               stall,
    input  cpu_pkg::reg_addr_t dest,
    input  cpu_pkg::reg_addr_t src1,
    input  cpu_pkg::reg_addr_t src2,
    input  cpu_pkg::data_t     alu_result,
    input  cpu_pkg::data_t     load_data,
    output cpu_pkg::data_t     rdata1,
    output cpu_pkg::data_t     rdata2
);

    cpu_pkg::data_t regs [`REG_COUNT];
    cpu_pkg::data_t wdata;

    // write-back source
    assign wdata = ctrl.wb_from_mem ? load_data : alu_result;

    assign rdata1 = regs[src1];
    assign rdata2 = regs[src2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && !stall) begin  // held while a miss is served
            regs[dest] <= wdata;
        end
    end

endmodule

// File: execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit (
    input  cpu_pkg::ctrl_t ctrl,
    input  cpu_pkg::data_t rdata1,
    input  cpu_pkg::data_t rdata2,
    input  cpu_pkg::data_t immediate,
    output cpu_pkg::data_t alu_result,
    output logic           equal
);

    cpu_pkg::data_t operand_sel;
    cpu_pkg::data_t operand2;

    assign operand_sel = ctrl.use_reg_operand ? rdata2 : immediate;
    assign operand2    = ctrl.negate ? (~operand_sel + 1'b1) : operand_sel;  // for sub

    always_comb begin
        case (ctrl.alu_sel)
            `ALU_FWD: alu_result = operand2;
            `ALU_ADD: alu_result = rdata1 + operand2;
            `ALU_AND: alu_result = rdata1 & operand2;
            `ALU_OR:  alu_result = rdata1 | operand2;
            default:  alu_result = '0;
        endcase
    end

    // beq compares the two register values
    assign equal = (rdata1 == rdata2);

endmodule

// File: pc_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pc_unit (
    input  logic           clock,
    input  logic           reset,
    input  cpu_pkg::ctrl_t ctrl,
    input  logic           stall,
    input  logic           equal,
    input  cpu_pkg::data_t offset,
    output cpu_pkg::pc_t   pc
);

    cpu_pkg::pc_t pc_plus4;
    cpu_pkg::pc_t offset_ext;
    cpu_pkg::pc_t next_pc;
    logic         take;

    assign pc_plus4 = pc + `PC_W'(4);

    // sign-extended word offset
    assign offset_ext = {{(`PC_W - `DATA_W - 2){offset[`DATA_W-1]}}, offset, 2'b00};

    assign take    = ctrl.jump || (ctrl.branch && equal);
    assign next_pc = take ? (pc_plus4 + offset_ext) : pc_plus4;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

endmodule

// File: data_cache.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module data_cache (
    input  logic              clock,
    input  logic              reset,
    input  cpu_pkg::ctrl_t    ctrl,
    input  cpu_pkg::data_t    address,
    input  cpu_pkg::data_t    writedata,
    input  logic              mem_busywait,
    input  cpu_pkg::block_t   mem_readdata,
    output cpu_pkg::data_t    load_data,
    output logic              stall,
    output cpu_pkg::mem_req_t mem_req
);

    localparam int INDEX_W = `BLOCK_ADDR_W - `TAG_W;

    cpu_pkg::block_t         data_array [`CACHE_LINES];
    logic [`TAG_W-1:0]       tag_array [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_bits;
    logic [`CACHE_LINES-1:0] dirty_bits;

    cpu_pkg::cache_state_e state;
    cpu_pkg::cache_state_e next_state;
    cpu_pkg::block_t       fill_block;  // block fetched from memory

    logic [`TAG_W-1:0] tag;
    logic [INDEX_W-1:0] index;
    logic [1:0]         byte_sel;
    logic               access;
    logic               hit;
    logic               victim_dirty;

    assign {tag, index, byte_sel} = address;

    assign access       = ctrl.mem_read || ctrl.mem_write;
    assign hit          = valid_bits[index] && (tag_array[index] == tag);
    assign victim_dirty = valid_bits[index] && dirty_bits[index];
    assign stall        = access && !hit;

    // byte 0 sits in block bits 7..0
    assign load_data = data_array[index][{byte_sel, 3'b000} +: `DATA_W];

    always_comb begin
        next_state = state;
        case (state)
            cpu_pkg::IDLE: begin
                if (stall) begin
                    next_state = victim_dirty ? cpu_pkg::WRITE_BACK : cpu_pkg::MEM_READ;
                end
            end
            cpu_pkg::WRITE_BACK: begin
                if (!mem_busywait) begin
                    next_state = cpu_pkg::MEM_READ;
                end
            end
            cpu_pkg::MEM_READ: begin
                if (!mem_busywait) begin
                    next_state = cpu_pkg::UPDATE;
                end
            end
            cpu_pkg::UPDATE: next_state = cpu_pkg::IDLE;
            default:         next_state = cpu_pkg::IDLE;
        endcase
    end

    // request levels held for the whole state
    always_comb begin
        mem_req = '0;
        case (state)
            cpu_pkg::WRITE_BACK: begin
                mem_req.write      = 1'b1;
                mem_req.block_addr = {tag_array[index], index};  // victim block
                mem_req.writedata  = data_array[index];
            end
            cpu_pkg::MEM_READ: begin
                mem_req.read       = 1'b1;
                mem_req.block_addr = {tag, index};
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= cpu_pkg::IDLE;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            state <= next_state;
            if (state == cpu_pkg::UPDATE) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= 1'b0;  // fresh copy of memory
            end else if (ctrl.mem_write && hit) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == cpu_pkg::MEM_READ && !mem_busywait) begin
            fill_block <= mem_readdata;  // readdata valid in the completing cycle
        end
        if (state == cpu_pkg::UPDATE) begin
            data_array[index] <= fill_block;
            tag_array[index]  <= tag;
        end else if (ctrl.mem_write && hit) begin
            data_array[index][{byte_sel, 3'b000} +: `DATA_W] <= writedata;
        end
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic              clock,
    input  logic              reset,
    input  cpu_pkg::instr_t   instruction,
    input  logic              mem_busywait,
    input  cpu_pkg::block_t   mem_readdata,
    output cpu_pkg::pc_t      pc,
    output cpu_pkg::mem_req_t mem_req
);

    cpu_pkg::ctrl_t ctrl;
    cpu_pkg::data_t rdata1;
    cpu_pkg::data_t rdata2;
    cpu_pkg::data_t alu_result;  // also the data address
    cpu_pkg::data_t load_data;
    logic           equal;
    logic           stall;

    instr_decoder u_decoder (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    reg_file u_reg_file (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl),
        .stall      (stall),
        .dest       (instruction[18:16]),
        .src1       (instruction[10:8]),
        .src2       (instruction[2:0]),
        .alu_result (alu_result),
        .load_data  (load_data),
        .rdata1     (rdata1),
        .rdata2     (rdata2)
    );

    execute_unit u_execute (
        .ctrl       (ctrl),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .immediate  (instruction[7:0]),
        .alu_result (alu_result),
        .equal      (equal)
    );

    pc_unit u_pc (
        .clock  (clock),
        .reset  (reset),
        .ctrl   (ctrl),
        .stall  (stall),
        .equal  (equal),
        .offset (instruction[23:16]),
        .pc     (pc)
    );

    // stores write source 1
    data_cache u_dcache (
        .clock        (clock),
        .reset        (reset),
        .ctrl         (ctrl),
        .address      (alu_result),
        .writedata    (rdata1),
        .mem_busywait (mem_busywait),
        .mem_readdata (mem_readdata),
        .load_data    (load_data),
        .stall        (stall),
        .mem_req      (mem_req)
    );

endmodule

// File: tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_top;

    localparam int MEM_LATENCY = 3;
    localparam int N_RANDOM    = 300;
    localparam int N_FLUSH     = 2 * `CACHE_LINES;
    localparam int PROG_LEN    = N_RANDOM + N_FLUSH;
    localparam int END_PC      = PROG_LEN * 4;
    // dirty miss is the slowest instruction
    localparam int MAX_CYCLES  = PROG_LEN * (2 * (MEM_LATENCY + 2) + 2) + 50;

    logic              clock;
    logic              reset;
    cpu_pkg::instr_t   instruction;
    logic              mem_busywait;
    cpu_pkg::block_t   mem_readdata;
    cpu_pkg::pc_t      pc;
    cpu_pkg::mem_req_t mem_req;

    cpu_pkg::instr_t         imem [PROG_LEN];
    cpu_pkg::data_t          dmem [256];     // behind the memory port
    cpu_pkg::data_t          ref_mem [256];  // architectural view
    cpu_pkg::data_t          ref_regs [`REG_COUNT];
    logic [`TAG_W-1:0]       shadow_tag [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] shadow_valid;
    logic [`CACHE_LINES-1:0] shadow_dirty;

    integer               seed;
    int                   value_errors;
    int                   other_errors;
    int                   cycles;
    int                   req_age;  // cycles the current request has waited
    logic                 stop_run;
    cpu_pkg::pc_t         model_pc;
    cpu_pkg::pc_t         prev_pc;
    logic                 miss_expected;
    logic                 wb_pending;
    logic                 rd_pending;
    cpu_pkg::block_addr_t wb_addr_exp;
    cpu_pkg::block_addr_t rd_addr_exp;

    cpu_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .instruction  (instruction),
        .mem_busywait (mem_busywait),
        .mem_readdata (mem_readdata),
        .pc           (pc),
        .mem_req      (mem_req)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic cpu_pkg::instr_t fetch(input cpu_pkg::pc_t addr);
        if (addr[1:0] == 2'b00 && (addr >> 2) < PROG_LEN) begin
            return imem[addr >> 2];
        end
        return 32'hff00_0000;  // unknown opcode
    endfunction

    function automatic cpu_pkg::block_t ref_block(input cpu_pkg::block_addr_t b);
        return {ref_mem[{b, 2'd3}], ref_mem[{b, 2'd2}], ref_mem[{b, 2'd1}], ref_mem[{b, 2'd0}]};
    endfunction

    function automatic cpu_pkg::block_t dmem_block(input cpu_pkg::block_addr_t b);
        return {dmem[{b, 2'd3}], dmem[{b, 2'd2}], dmem[{b, 2'd1}], dmem[{b, 2'd0}]};
    endfunction

    function automatic cpu_pkg::data_t access_addr(input cpu_pkg::instr_t ins);
        if (ins[31:24] == `OP_LWD || ins[31:24] == `OP_SWD) begin
            return ref_regs[ins[2:0]];  // register indirect
        end
        return ins[7:0];
    endfunction

    function automatic logic is_mem_op(input cpu_pkg::instr_t ins);
        return ins[31:24] >= `OP_LWD && ins[31:24] <= `OP_SWI;
    endfunction

    task automatic build_program();
        logic [7:0] op;
        int         span;
        for (int i = 0; i < N_RANDOM; i++) begin
            op      = 8'({$random(seed)} % 12);
            imem[i] = {op, 24'($random(seed))};
            if (op == `OP_BEQ || op == `OP_J) begin
                span = N_RANDOM - 1 - i;  // forward only, never past the flush
                if (span > 3) begin
                    span = 3;
                end
                imem[i][23:16] = 8'({$random(seed)} % (span + 1));
            end
        end
        // two tags per line, so every dirty line gets written back
        for (int k = 0; k < N_FLUSH; k++) begin
            imem[N_RANDOM + k] = {`OP_LWI, 5'd0, 3'(k % 8), 8'h00,
                                  3'(k / `CACHE_LINES), 3'(k % `CACHE_LINES), 2'b00};
        end
    endtask

    // expected memory traffic of the instruction at model_pc
    task automatic predict_access();
        cpu_pkg::instr_t ins;
        cpu_pkg::data_t  addr;
        logic [2:0]      idx;
        ins           = fetch(model_pc);
        addr          = access_addr(ins);
        idx           = addr[4:2];
        miss_expected = 1'b0;
        wb_pending    = 1'b0;
        rd_pending    = 1'b0;
        if (is_mem_op(ins) && !(shadow_valid[idx] && shadow_tag[idx] == addr[7:5])) begin
            miss_expected = 1'b1;
            rd_pending    = 1'b1;
            rd_addr_exp   = addr[7:2];
            if (shadow_valid[idx] && shadow_dirty[idx]) begin
                wb_pending  = 1'b1;
                wb_addr_exp = {shadow_tag[idx], idx};
            end
        end
    endtask

    task automatic retire_model();
        cpu_pkg::instr_t    ins;
        cpu_pkg::data_t     a;
        cpu_pkg::data_t     b;
        cpu_pkg::data_t     addr;
        cpu_pkg::reg_addr_t d;
        logic [2:0]         idx;
        cpu_pkg::pc_t       next_pc;
        ins     = fetch(model_pc);
        a       = ref_regs[ins[10:8]];
        b       = ref_regs[ins[2:0]];
        d       = ins[18:16];
        addr    = access_addr(ins);
        idx     = addr[4:2];
        next_pc = model_pc + 32'd4;
        if (is_mem_op(ins) && !(shadow_valid[idx] && shadow_tag[idx] == addr[7:5])) begin
            shadow_valid[idx] = 1'b1;  // refilled, clean
            shadow_dirty[idx] = 1'b0;
            shadow_tag[idx]   = addr[7:5];
        end
        case (ins[31:24])
            `OP_LOADI: ref_regs[d] = ins[7:0];
            `OP_MOV:   ref_regs[d] = b;
            `OP_ADD:   ref_regs[d] = a + b;
            `OP_SUB:   ref_regs[d] = a - b;
            `OP_AND:   ref_regs[d] = a & b;
            `OP_OR:    ref_regs[d] = a | b;
            `OP_BEQ: begin
                if (a == b) begin
                    next_pc = next_pc + {{22{ins[23]}}, ins[23:16], 2'b00};
                end
            end
            `OP_J:             next_pc = next_pc + {{22{ins[23]}}, ins[23:16], 2'b00};
            `OP_LWD, `OP_LWI:  ref_regs[d] = ref_mem[addr];
            `OP_SWD, `OP_SWI: begin
                ref_mem[addr]     = a;
                shadow_dirty[idx] = 1'b1;
            end
            default: ;
        endcase
        model_pc = next_pc;
    endtask

    // memory side of a request seen without busywait
    task automatic complete_access(input cpu_pkg::mem_req_t req);
        if (req.write) begin
            if (!wb_pending) begin
                other_errors++;
                $display("unexpected write-back of block %h at %0t", req.block_addr, $time);
            end else if (req.block_addr !== wb_addr_exp) begin
                value_errors++;
                $display("ERR %0t mem_req.block_addr expected %h got %h",
                         $time, wb_addr_exp, req.block_addr);
            end else if (req.writedata !== ref_block(wb_addr_exp)) begin
                value_errors++;
                $display("ERR %0t mem_req.writedata expected %h got %h",
                         $time, ref_block(wb_addr_exp), req.writedata);
            end
            wb_pending = 1'b0;
            for (int i = 0; i < 4; i++) begin
                dmem[{req.block_addr, 2'(i)}] = req.writedata[i*8 +: 8];
            end
        end else begin
            if (!rd_pending || wb_pending) begin
                other_errors++;
                $display("unexpected memory read of block %h at %0t", req.block_addr, $time);
            end else if (req.block_addr !== rd_addr_exp) begin
                value_errors++;
                $display("ERR %0t mem_req.block_addr expected %h got %h",
                         $time, rd_addr_exp, req.block_addr);
            end
            rd_pending = 1'b0;
        end
    endtask

    task automatic drive_inputs();
        // request levels follow the cache FSM state, settled since the edge
        mem_busywait = (mem_req.read || mem_req.write) && (req_age < MEM_LATENCY);
        if (mem_req.read && !mem_busywait) begin
            mem_readdata = dmem_block(mem_req.block_addr);
        end
        instruction = fetch(pc);
    endtask

    task automatic sample_cycle();
        if (mem_req.read || mem_req.write) begin
            if (!mem_busywait) begin
                complete_access(mem_req);
                req_age = 0;
            end else begin
                req_age++;
            end
        end else begin
            req_age = 0;
        end
        if (pc != prev_pc) begin
            if (wb_pending || rd_pending) begin
                other_errors++;
                $display("instruction at pc %h finished without its memory traffic", prev_pc);
            end
            retire_model();
            if (pc !== model_pc) begin
                value_errors++;
                $display("ERR %0t pc expected %h got %h", $time, model_pc, pc);
                stop_run = 1'b1;
            end
            prev_pc = pc;
            predict_access();
        end else if (!miss_expected) begin
            other_errors++;
            $display("pc stuck at %h although no cache miss was expected", pc);
            stop_run = 1'b1;
        end
    endtask

    initial begin
        seed         = 32'h61ccb0f0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        req_age      = 0;
        stop_run     = 1'b0;
        shadow_valid = '0;
        shadow_dirty = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]    = 8'(i * 37 + 11);
            ref_mem[i] = 8'(i * 37 + 11);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            ref_regs[i]   = '0;
            shadow_tag[i] = '0;
        end
        build_program();
        reset        = 1'b1;
        instruction  = imem[0];
        mem_busywait = 1'b0;
        mem_readdata = '0;
        repeat (3) @(posedge clock);
        #1;
        reset       = 1'b0;
        instruction = fetch(pc);
        @(negedge clock);
        if (pc !== '0) begin
            value_errors++;
            $display("ERR %0t pc expected %h got %h", $time, 32'h0, pc);
        end
        if (mem_req.read !== 1'b0 || mem_req.write !== 1'b0) begin
            value_errors++;
            $display("ERR %0t mem_req.read/write expected 00 got %b%b",
                     $time, mem_req.read, mem_req.write);
        end
        model_pc = '0;
        prev_pc  = '0;
        predict_access();
        while (model_pc != END_PC && !stop_run) begin
            @(posedge clock);
            #1;
            drive_inputs();
            @(negedge clock);
            sample_cycle();
            cycles++;
            if (cycles > MAX_CYCLES) begin
                other_errors++;
                $display("timeout after %0d cycles, dut pc %h", cycles, pc);
                stop_run = 1'b1;
            end
        end
        // after the flush loads, memory must hold every store
        if (!stop_run) begin
            for (int i = 0; i < 256; i++) begin
                if (dmem[i] !== ref_mem[i]) begin
                    value_errors++;
                    $display("ERR %0t dmem[%h] expected %h got %h", $time, i, ref_mem[i], dmem[i]);
                end
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
cpu_pkg.sv
instr_decoder.sv
reg_file.sv
execute_unit.sv
pc_unit.sv
data_cache.sv
cpu_top.sv
tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_cpu_top > build.log 2>&1 &&
./obj_dir/Vtb_cpu_top > sim.log 2>&1 &&
! grep -q "TEST RESULT: FAIL" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
